// File: hw/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // fixed-point word format, signed with FRAC_W fractional bits
    localparam int WORD_W = 16;
    localparam int FRAC_W = 8;

    // frame and kernel geometry
    // the frame is exactly one kernel wide, so kernels only slide down
    localparam int IN_HEIGHT = 8;
    localparam int K_HEIGHT  = 3;
    localparam int K_WIDTH   = 2;
    localparam int N_KERNELS = 2;
    localparam int OUT_ROWS  = IN_HEIGHT - K_HEIGHT + 1;

    // full-precision sum of K_HEIGHT*K_WIDTH products plus the bias,
    // comfortably wider than 2*WORD_W plus growth bits
    localparam int ACC_W = 40;

    // kernel memory: row-major weights of kernel k, then its bias
    localparam int KMEM_STRIDE = K_HEIGHT * K_WIDTH + 1;
    localparam int KMEM_DEPTH  = N_KERNELS * KMEM_STRIDE;
    localparam int KMEM_ADDR_W = $clog2(KMEM_DEPTH);

    // row counter runs up to IN_HEIGHT after the final row is taken in
    localparam int ROW_W  = $clog2(IN_HEIGHT + 1);
    localparam int COL_W  = (K_WIDTH > 1) ? $clog2(K_WIDTH) : 1;
    localparam int SLOT_W = (K_HEIGHT > 1) ? $clog2(K_HEIGHT) : 1;

    // frame controller
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_STREAM = 2'd1,
        S_OUTPUT = 2'd2
    } conv_state_e;

endpackage

`default_nettype wire

// File: hw/kernel_mem.sv
`default_nettype none

module kernel_mem
    import conv_pkg::*;
(
    input  wire                                      clk_i,
    input  wire                                      reset_i,
    // write side, already gated to idle by the top level
    input  wire                                      wr_en_i,
    input  wire  [KMEM_ADDR_W-1:0]                   wr_addr_i,
    input  wire  [WORD_W-1:0]                        wr_data_i,
    // column of the word currently on the input stream
    input  wire  [COL_W-1:0]                         col_i,
    // kernel k, row a sits in word k*K_HEIGHT + a
    output logic [N_KERNELS*K_HEIGHT*WORD_W-1:0]     weights_o,
    output logic [N_KERNELS*WORD_W-1:0]              biases_o
);

    logic [WORD_W-1:0] mem_r [KMEM_DEPTH];

    // addresses past the last bias are dropped
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < KMEM_DEPTH; i++) begin
                mem_r[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i < KMEM_ADDR_W'(KMEM_DEPTH))) begin
            mem_r[wr_addr_i] <= wr_data_i;
        end
    end

    // read ports: every kernel row at the current column, all at once
    for (genvar k = 0; k < N_KERNELS; k++) begin : g_kernel
        for (genvar a = 0; a < K_HEIGHT; a++) begin : g_row
            // base of row a inside kernel k
            localparam int ROW_BASE = k * KMEM_STRIDE + a * K_WIDTH;

            assign weights_o[(k*K_HEIGHT+a)*WORD_W +: WORD_W] =
                mem_r[ROW_BASE + int'(col_i)];
        end

        // bias follows the last weight of the kernel
        assign biases_o[k*WORD_W +: WORD_W] = mem_r[k*KMEM_STRIDE + K_HEIGHT*K_WIDTH];
    end

endmodule

`default_nettype wire

// File: hw/mac_unit.sv
`default_nettype none

module mac_unit
    import conv_pkg::*;
(
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       en_i,
    input  wire                       clear_i,
    input  wire  signed [WORD_W-1:0]  weight_i,
    input  wire  signed [WORD_W-1:0]  data_i,
    input  wire  signed [WORD_W-1:0]  bias_i,
    output logic signed [WORD_W-1:0]  result_o
);

    logic signed [2*WORD_W-1:0] product;
    logic signed [ACC_W-1:0]    product_ext;
    logic signed [ACC_W-1:0]    acc_r;
    logic signed [ACC_W-1:0]    bias_ext;
    logic signed [ACC_W-1:0]    total;
    logic signed [ACC_W-1:0]    scaled;
    // bits that must all match the sign for the word to fit
    logic        [ACC_W-WORD_W:0] upper;

    // full-precision product, sign-extended to the accumulator
    assign product     = weight_i * data_i;
    assign product_ext = {{(ACC_W-2*WORD_W){product[2*WORD_W-1]}}, product};

    // clear wins over a same-cycle enable
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            acc_r <= '0;
        end else if (en_i) begin
            acc_r <= acc_r + product_ext;
        end
    end

    // bias lines up with the product's fractional point
    assign bias_ext = {{(ACC_W-WORD_W){bias_i[WORD_W-1]}}, bias_i};
    assign total    = acc_r + (bias_ext <<< FRAC_W);

    // back to WORD_W format, rounding toward minus infinity
    assign scaled = total >>> FRAC_W;
    assign upper  = scaled[ACC_W-1:WORD_W-1];

    always_comb begin
        if ((&upper) || !(|upper)) begin
            result_o = scaled[WORD_W-1:0];
        end else if (scaled[ACC_W-1]) begin
            // clip to most negative word
            result_o = {1'b1, {(WORD_W-1){1'b0}}};
        end else begin
            // clip to most positive word
            result_o = {1'b0, {(WORD_W-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_lane.sv
`default_nettype none

module conv_lane
    import conv_pkg::*;
(
    input  wire                          clk_i,
    input  wire                          reset_i,
    // one pulse per accepted input word
    input  wire                          acc_en_i,
    // one pulse per accepted output row
    input  wire                          clear_i,
    input  wire  [ROW_W-1:0]             row_i,
    input  wire  [SLOT_W-1:0]            out_slot_i,
    input  wire  signed [WORD_W-1:0]     data_i,
    // this kernel's weights at the current column, row 0 in the low word
    input  wire  [K_HEIGHT*WORD_W-1:0]   weights_i,
    input  wire  signed [WORD_W-1:0]     bias_i,
    output logic signed [WORD_W-1:0]     result_o
);

    logic signed [WORD_W-1:0] weight_row [K_HEIGHT];
    logic signed [WORD_W-1:0] slot_weight [K_HEIGHT];
    logic signed [WORD_W-1:0] slot_result [K_HEIGHT];
    logic [K_HEIGHT-1:0]      slot_en;
    logic [K_HEIGHT-1:0]      slot_clear;
    // input row modulo K_HEIGHT, shared by all slots
    logic [ROW_W-1:0]         row_mod;

    for (genvar a = 0; a < K_HEIGHT; a++) begin : g_unpack
        assign weight_row[a] = weights_i[a*WORD_W +: WORD_W];
    end

    assign row_mod = row_i % ROW_W'(K_HEIGHT);

    // slot s collects output rows o with o mod K_HEIGHT == s
    for (genvar s = 0; s < K_HEIGHT; s++) begin : g_slot
        // kernel row that the current input row feeds in this slot
        logic [ROW_W-1:0] krow;
        logic             in_range;

        // (row - s) mod K_HEIGHT without a negative intermediate
        assign krow = (row_mod >= ROW_W'(s)) ? (row_mod - ROW_W'(s))
                                             : (row_mod + ROW_W'(K_HEIGHT - s));

        // target output row row_i - krow must exist
        assign in_range = (krow <= row_i) &&
                          ((row_i - krow) <= ROW_W'(OUT_ROWS - 1));

        assign slot_en[s]     = acc_en_i && in_range;
        assign slot_weight[s] = weight_row[krow[SLOT_W-1:0]];

        // only the finished slot is wiped on acceptance
        assign slot_clear[s] = clear_i && (out_slot_i == SLOT_W'(s));

        mac_unit i_mac_unit (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .en_i     (slot_en[s]),
            .clear_i  (slot_clear[s]),
            .weight_i (slot_weight[s]),
            .data_i   (data_i),
            .bias_i   (bias_i),
            .result_o (slot_result[s])
        );
    end

    // finished row goes out from the slot the controller points at
    assign result_o = slot_result[out_slot_i];

endmodule

`default_nettype wire

// File: hw/conv_ctrl.sv
`default_nettype none

module conv_ctrl
    import conv_pkg::*;
(
    input  wire               clk_i,
    input  wire               reset_i,
    input  wire               start_i,
    // input stream side
    input  wire               valid_i,
    // output row side
    input  wire               ready_i,
    output logic              conv_ready_o,
    output logic              yumi_o,
    output logic              valid_o,
    // datapath strobes
    output logic              acc_en_o,
    output logic              clear_o,
    // position of the word on the input stream
    output logic [ROW_W-1:0]  row_o,
    output logic [COL_W-1:0]  col_o,
    // slot holding the row that valid_o presents
    output logic [SLOT_W-1:0] out_slot_o
);

    conv_state_e state_r;
    conv_state_e state_n;

    logic [COL_W-1:0]  col_r;
    logic [ROW_W-1:0]  row_r;
    // row_r mod K_HEIGHT, kept as its own counter to avoid a divider
    logic [SLOT_W-1:0] slot_r;

    logic accept;
    logic last_col;
    logic row_done;
    logic enter_idle;

    // words only come in while streaming
    assign yumi_o   = (state_r == S_STREAM) && valid_i;
    assign accept   = yumi_o;
    assign last_col = (col_r == COL_W'(K_WIDTH - 1));
    assign row_done = accept && last_col;

    assign conv_ready_o = (state_r == S_IDLE);
    assign valid_o      = (state_r == S_OUTPUT);

    assign acc_en_o = accept;
    assign clear_o  = valid_o && ready_i;

    // next state
    always_comb begin
        state_n = state_r;
        case (state_r)
            S_IDLE: begin
                if (start_i) begin
                    state_n = S_STREAM;
                end
            end
            S_STREAM: begin
                // once K_HEIGHT rows are in, every finished row completes an output
                if (row_done && (row_r >= ROW_W'(K_HEIGHT - 1))) begin
                    state_n = S_OUTPUT;
                end
            end
            S_OUTPUT: begin
                if (ready_i) begin
                    // row_r has already moved past the final input row
                    if (row_r == ROW_W'(IN_HEIGHT)) begin
                        state_n = S_IDLE;
                    end else begin
                        state_n = S_STREAM;
                    end
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= S_IDLE;
        end else begin
            state_r <= state_n;
        end
    end

    assign enter_idle = (state_r != S_IDLE) && (state_n == S_IDLE);

    // column, row and slot counters advance on accepted words only
    always_ff @(posedge clk_i) begin
        if (reset_i || enter_idle) begin
            col_r  <= '0;
            row_r  <= '0;
            slot_r <= '0;
        end else if (accept) begin
            if (last_col) begin
                col_r <= '0;
                row_r <= row_r + 1'b1;
                // wrap at K_HEIGHT
                if (slot_r == SLOT_W'(K_HEIGHT - 1)) begin
                    slot_r <= '0;
                end else begin
                    slot_r <= slot_r + 1'b1;
                end
            end else begin
                col_r <= col_r + 1'b1;
            end
        end
    end

    assign row_o      = row_r;
    assign col_o      = col_r;
    // after row r ends, slot_r is (r + 1) mod K_HEIGHT, the finished slot
    assign out_slot_o = slot_r;

endmodule

`default_nettype wire

// File: hw/conv_layer.sv
`default_nettype none

module conv_layer
    import conv_pkg::*;
(
    input  wire                             clk_i,
    input  wire                             reset_i,
    input  wire                             start_i,
    output logic                            conv_ready_o,
    // kernel weight and bias writes
    input  wire                             wr_en_i,
    input  wire  [KMEM_ADDR_W-1:0]          wr_addr_i,
    input  wire  [WORD_W-1:0]               wr_data_i,
    // input stream
    input  wire                             valid_i,
    input  wire  signed [WORD_W-1:0]        data_i,
    output logic                            yumi_o,
    // output rows, kernel k in slice k
    output logic                            valid_o,
    input  wire                             ready_i,
    output logic [N_KERNELS*WORD_W-1:0]     data_o
);

    logic                                  acc_en;
    logic                                  clear;
    logic [ROW_W-1:0]                      row;
    logic [COL_W-1:0]                      col;
    logic [SLOT_W-1:0]                     out_slot;
    logic                                  wr_en_idle;
    logic [N_KERNELS*K_HEIGHT*WORD_W-1:0]  weights;
    logic [N_KERNELS*WORD_W-1:0]           biases;

    // weights may only change between frames
    assign wr_en_idle = wr_en_i && conv_ready_o;

    conv_ctrl i_conv_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .valid_i      (valid_i),
        .ready_i      (ready_i),
        .conv_ready_o (conv_ready_o),
        .yumi_o       (yumi_o),
        .valid_o      (valid_o),
        .acc_en_o     (acc_en),
        .clear_o      (clear),
        .row_o        (row),
        .col_o        (col),
        .out_slot_o   (out_slot)
    );

    kernel_mem i_kernel_mem (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en_idle),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .col_i     (col),
        .weights_o (weights),
        .biases_o  (biases)
    );

    // one lane per kernel, all sharing the same stream and strobes
    for (genvar k = 0; k < N_KERNELS; k++) begin : g_lane
        conv_lane i_conv_lane (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .acc_en_i   (acc_en),
            .clear_i    (clear),
            .row_i      (row),
            .out_slot_i (out_slot),
            .data_i     (data_i),
            .weights_i  (weights[k*K_HEIGHT*WORD_W +: K_HEIGHT*WORD_W]),
            .bias_i     (biases[k*WORD_W +: WORD_W]),
            .result_o   (data_o[k*WORD_W +: WORD_W])
        );
    end

endmodule

`default_nettype wire

// File: sim/conv_layer_tb.sv
`default_nettype none

module conv_layer_tb
    import conv_pkg::*;
;

    localparam int N_WORDS     = IN_HEIGHT * K_WIDTH;
    localparam int FRAME_LIMIT = 2000;
    localparam int IDLE_LIMIT  = 10;

    logic                          clk_i;
    logic                          reset_i;
    logic                          start_i;
    logic                          conv_ready_o;
    logic                          wr_en_i;
    logic [KMEM_ADDR_W-1:0]        wr_addr_i;
    logic [WORD_W-1:0]             wr_data_i;
    logic                          valid_i;
    logic [WORD_W-1:0]             data_i;
    logic                          yumi_o;
    logic                          valid_o;
    logic                          ready_i;
    logic [N_KERNELS*WORD_W-1:0]   data_o;

    // reference copies of what was written while idle
    int w_m [N_KERNELS][K_HEIGHT][K_WIDTH];
    int bias_m [N_KERNELS];
    int frame_m [N_WORDS];
    logic [N_KERNELS*WORD_W-1:0] exp_q [$];

    integer seed = 7;
    int data_errs = 0;
    int proto_errs = 0;
    int timeout_errs = 0;
    bit timed_out = 0;

    conv_layer i_conv_layer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .conv_ready_o (conv_ready_o),
        .wr_en_i      (wr_en_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .valid_i      (valid_i),
        .data_i       (data_i),
        .yumi_o       (yumi_o),
        .valid_o      (valid_o),
        .ready_i      (ready_i),
        .data_o       (data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // signed value in -mag..mag
    function automatic int rand_range(input int mag);
        int r;
        r = $random(seed);
        return r % (mag + 1);
    endfunction

    // uniform 0..99
    function automatic int rand_pct();
        int r;
        r = $random(seed);
        return ((r % 100) + 100) % 100;
    endfunction

    // sum of products, bias at the product's binary point, floor shift, clip
    function automatic logic [WORD_W-1:0] model_word(input int k, input int o);
        longint acc;
        longint max_w;
        acc = 0;
        max_w = (longint'(1) <<< (WORD_W - 1)) - 1;
        for (int a = 0; a < K_HEIGHT; a++) begin
            for (int b = 0; b < K_WIDTH; b++) begin
                acc += longint'(frame_m[(o + a) * K_WIDTH + b]) * longint'(w_m[k][a][b]);
            end
        end
        acc += longint'(bias_m[k]) <<< FRAC_W;
        acc = acc >>> FRAC_W;
        if (acc > max_w) acc = max_w;
        if (acc < -max_w - 1) acc = -max_w - 1;
        return acc[WORD_W-1:0];
    endfunction

    // single write, entered and left just after a rising edge
    task automatic write_word(input int addr, input int val);
        wr_en_i = 1'b1;
        wr_addr_i = KMEM_ADDR_W'(addr);
        wr_data_i = WORD_W'(val);
        @(posedge clk_i);
        #1;
        wr_en_i = 1'b0;
    endtask

    task automatic load_kernels(input int wmag, input int bmag);
        for (int k = 0; k < N_KERNELS; k++) begin
            for (int a = 0; a < K_HEIGHT; a++) begin
                for (int b = 0; b < K_WIDTH; b++) begin
                    w_m[k][a][b] = rand_range(wmag);
                    write_word(k * KMEM_STRIDE + a * K_WIDTH + b, w_m[k][a][b]);
                end
            end
            bias_m[k] = rand_range(bmag);
            write_word(k * KMEM_STRIDE + K_HEIGHT * K_WIDTH, bias_m[k]);
        end
    endtask

    // idle outputs hold even with valid_i offered
    task automatic check_idle(input int n);
        valid_i = 1'b1;
        repeat (n) begin
            @(negedge clk_i);
            if (!conv_ready_o || valid_o || yumi_o) begin
                $display("FAIL %0t: idle outputs wrong, ready %b valid %b yumi %b",
                         $time, conv_ready_o, valid_o, yumi_o);
                proto_errs++;
            end
            @(posedge clk_i);
            #1;
        end
        valid_i = 1'b0;
    endtask

    task automatic compare_row(input int o);
        logic [N_KERNELS*WORD_W-1:0] exp_row;
        exp_row = exp_q.pop_front();
        for (int k = 0; k < N_KERNELS; k++) begin
            if (data_o[k*WORD_W +: WORD_W] !== exp_row[k*WORD_W +: WORD_W]) begin
                $display("FAIL %0t: kernel %0d row %0d got %0d expected %0d", $time, k, o,
                         $signed(data_o[k*WORD_W +: WORD_W]),
                         $signed(exp_row[k*WORD_W +: WORD_W]));
                data_errs++;
            end
        end
    endtask

    // one frame; gap and back-pressure in percent, optional write mid-frame
    task automatic run_frame(input int gap_pct, input int bp_pct, input bit stray_wr,
                             input int mag);
        int wi;
        int n_out;
        int cycles;
        bit streaming;
        bit expect_rise;
        bit prev_valid;
        bit prev_ready;
        logic [N_KERNELS*WORD_W-1:0] prev_data;
        logic [N_KERNELS*WORD_W-1:0] exp_row;
        wi = 0;
        n_out = 0;
        cycles = 0;
        expect_rise = 0;
        prev_valid = 0;
        prev_ready = 0;
        prev_data = '0;
        exp_q.delete();
        for (int i = 0; i < N_WORDS; i++) begin
            frame_m[i] = rand_range(mag);
        end
        for (int o = 0; o < OUT_ROWS; o++) begin
            for (int k = 0; k < N_KERNELS; k++) begin
                exp_row[k*WORD_W +: WORD_W] = model_word(k, o);
            end
            exp_q.push_back(exp_row);
        end
        start_i = 1'b1;
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        // expected phase, tracked from the words and rows handed over
        streaming = 1;
        while (n_out < OUT_ROWS && cycles < FRAME_LIMIT) begin
            valid_i = (wi < N_WORDS) && (rand_pct() >= gap_pct);
            data_i = (wi < N_WORDS) ? WORD_W'(frame_m[wi]) : '0;
            ready_i = (rand_pct() >= bp_pct);
            // this write must be dropped since the layer is busy
            wr_en_i = stray_wr && (cycles == 3);
            wr_addr_i = KMEM_ADDR_W'((rand_range(KMEM_DEPTH - 1) + KMEM_DEPTH) % KMEM_DEPTH);
            wr_data_i = WORD_W'($random(seed));
            @(negedge clk_i);
            if (yumi_o !== (valid_i && streaming)) begin
                $display("FAIL %0t: yumi_o %b with valid_i %b streaming %b",
                         $time, yumi_o, valid_i, streaming);
                proto_errs++;
            end
            if (conv_ready_o) begin
                $display("layer reported idle at %0t before the frame ended", $time);
                proto_errs++;
            end
            if ((valid_o && !prev_valid) != expect_rise) begin
                $display("FAIL %0t: valid_o rise %b where %b was due",
                         $time, valid_o && !prev_valid, expect_rise);
                proto_errs++;
            end
            // held row under back-pressure
            if (prev_valid && !prev_ready && valid_o && data_o !== prev_data) begin
                $display("FAIL %0t: data_o changed while stalled", $time);
                proto_errs++;
            end
            if (valid_o && ready_i) begin
                compare_row(n_out);
                n_out++;
            end
            expect_rise = 0;
            if (yumi_o && valid_i) begin
                expect_rise = (wi % K_WIDTH == K_WIDTH - 1) && (wi / K_WIDTH >= K_HEIGHT - 1);
                wi++;
            end
            // a completing row stops the stream, an accepted output row resumes it
            if (expect_rise) begin
                streaming = 0;
            end else if (!streaming && ready_i) begin
                streaming = 1;
            end
            prev_valid = valid_o;
            prev_ready = ready_i;
            prev_data = data_o;
            @(posedge clk_i);
            #1;
            cycles++;
        end
        valid_i = 1'b0;
        ready_i = 1'b0;
        wr_en_i = 1'b0;
        if (n_out < OUT_ROWS) begin
            $display("timeout: only %0d of %0d output rows in %0d cycles",
                     n_out, OUT_ROWS, FRAME_LIMIT);
            timeout_errs++;
            timed_out = 1;
            return;
        end
        if (wi != N_WORDS) begin
            $display("frame finished after only %0d of %0d input words", wi, N_WORDS);
            proto_errs++;
        end
        // back to idle, and no extra row
        cycles = 0;
        @(negedge clk_i);
        while (!conv_ready_o && cycles < IDLE_LIMIT) begin
            @(posedge clk_i);
            #1;
            @(negedge clk_i);
            cycles++;
        end
        if (!conv_ready_o) begin
            $display("timeout: layer did not return to idle after the last row");
            timeout_errs++;
            timed_out = 1;
        end else if (valid_o) begin
            $display("layer presented an extra output row at %0t", $time);
            proto_errs++;
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_tests();
        check_idle(5);
        load_kernels(127, 255);
        run_frame(0, 0, 0, 511);
        if (timed_out) return;
        // input gaps
        run_frame(40, 0, 0, 511);
        if (timed_out) return;
        // output back-pressure
        run_frame(0, 40, 0, 511);
        if (timed_out) return;
        // busy writes mixed in, then fresh weights
        run_frame(30, 30, 1, 511);
        if (timed_out) return;
        load_kernels(255, 511);
        run_frame(20, 20, 1, 511);
        if (timed_out) return;
        run_frame(0, 0, 0, 511);
        if (timed_out) return;
        // large values drive the clip
        load_kernels(32767, 32767);
        run_frame(20, 20, 0, 32767);
        if (timed_out) return;
        run_frame(0, 0, 0, 32767);
    endtask

    initial begin
        reset_i = 1'b1;
        start_i = 1'b0;
        wr_en_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        valid_i = 1'b0;
        data_i = '0;
        ready_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        run_tests();
        $display("errors: %0d data, %0d protocol, %0d timeout",
                 data_errs, proto_errs, timeout_errs);
        if (data_errs + proto_errs + timeout_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/conv_pkg.sv
hw/kernel_mem.sv
hw/mac_unit.sv
hw/conv_lane.sv
hw/conv_ctrl.sv
hw/conv_layer.sv
sim/conv_layer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := conv_layer_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
